//--- rtl/aes_pkg.sv
/*
 * shared types of the AES-128 engine
 * state bytes, host control word, host word union,
 * host address codes, result record, xtime helper
 */
package aes_pkg;

    // byte 0 is the first input byte, column-major as in FIPS-197
    typedef logic [0:15][7:0] aes_state_t;

    // flags byte in the low bits of the host word
    typedef struct packed {
        logic [119:0] reserved;
        logic [7:0]   flags;
    } aes_ctrl_t;

    // start flag position in the flags byte
    localparam int flag_start = 0;

    // one host word, read as state bytes or as control
    typedef union packed {
        aes_state_t state;
        aes_ctrl_t  ctrl;
    } aes_host_word_u;

    // code 3 is unused but still acked
    typedef enum logic [1:0] {
        ADDR_CTRL = 2'd0,
        ADDR_KEY  = 2'd1,
        ADDR_DATA = 2'd2
    } aes_addr_e;

    typedef struct packed {
        aes_state_t data;
        logic [3:0] rounds;
    } aes_result_t;

    // multiply by x, reduction poly 0x11b
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

//--- rtl/aes_sbox.sv
`timescale 1ns/1ns
/*
 * AES S-box for one byte
 * GF(2^8) inverse by exponentiation, then the affine transform
 */
module aes_sbox
    import aes_pkg::*;
(
    input  logic [7:0] in,
    output logic [7:0] out
);

    logic [7:0] sq;
    logic [7:0] inv;

    // shift-and-add product in GF(2^8)
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = 8'h00;
        sh  = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ sh;
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // a^254 is the inverse, zero stays zero
    always_comb
    begin
        sq  = in;
        inv = 8'h01;
        // squares a^2 .. a^128 multiplied together
        for (int i = 1; i < 8; i++)
        begin
            sq  = gf_mul(sq, sq);
            inv = gf_mul(inv, sq);
        end
    end

    // affine step: inv ^ rotl 1..4 ^ 0x63
    assign out = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
               ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;

endmodule

//--- rtl/aes_mix_columns.sv
`timescale 1ns/1ns
/*
 * MixColumns over the full 16-byte state
 * each column times the fixed {02,03,01,01} circulant matrix
 */
module aes_mix_columns
    import aes_pkg::*;
(
    input  aes_state_t in,
    output aes_state_t out
);

    always_comb
    begin : mix
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        // four columns, bytes 4*c .. 4*c+3
        for (int c = 0; c < 4; c++)
        begin
            a0 = in[4*c];
            a1 = in[4*c + 1];
            a2 = in[4*c + 2];
            a3 = in[4*c + 3];
            // 03*x is xtime(x) ^ x
            out[4*c]     = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            out[4*c + 1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            out[4*c + 2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            out[4*c + 3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
    end

endmodule

//--- rtl/aes_round_datapath.sv
`timescale 1ns/1ns
/*
 * one AES encryption round, combinational
 * SubBytes, ShiftRows, MixColumns unless last round, AddRoundKey
 */
module aes_round_datapath
    import aes_pkg::*;
(
    input  aes_state_t state_in,
    input  aes_state_t round_key,
    input  logic       last_round,
    output aes_state_t state_out
);

    aes_state_t sub_bytes;
    aes_state_t shifted;
    aes_state_t mixed;

    // one S-box per state byte
    for (genvar i = 0; i < 16; i++)
    begin : g_sbox
        aes_sbox u_sbox (
            .in  (state_in[i]),
            .out (sub_bytes[i])
        );
    end

    // row r rotates left by r, byte index is 4*col + row
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                shifted[4*c + r] = sub_bytes[4*((c + r) % 4) + r];
        end
    end

    aes_mix_columns u_mix (
        .in  (shifted),
        .out (mixed)
    );

    // final round skips MixColumns
    assign state_out = (last_round ? shifted : mixed) ^ round_key;

endmodule

//--- rtl/aes_round_key.sv
`timescale 1ns/1ns
/*
 * round key register with on-the-fly AES-128 key expansion
 * RotWord, SubWord, round constant doubling
 */
module aes_round_key
    import aes_pkg::*;
(
    input  logic       OK_addRK,
    input  logic       resetn,
    input  logic       load,
    input  logic       advance,
    input  aes_state_t cipher_key,
    output aes_state_t round_key
);

    logic [7:0]      rcon;
    logic [0:3][7:0] rot_word;
    logic [0:3][7:0] sub_word;
    aes_state_t      next_key;

    // last key word rotated left by one byte
    assign rot_word = {round_key[13], round_key[14], round_key[15], round_key[12]};

    // SubWord
    for (genvar i = 0; i < 4; i++)
    begin : g_sbox
        aes_sbox u_sbox (
            .in  (rot_word[i]),
            .out (sub_word[i])
        );
    end

    always_comb
    begin
        // word 0 takes SubWord, rcon only on its first byte
        for (int j = 0; j < 4; j++)
            next_key[j] = round_key[j] ^ sub_word[j] ^ ((j == 0) ? rcon : 8'h00);
        // words 1..3 chain on the new previous word
        for (int i = 4; i < 16; i++)
            next_key[i] = round_key[i] ^ next_key[i - 4];
    end

    // round constant, 01 at each new key
    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
            rcon <= 8'h01;
        else if (load)
            rcon <= 8'h01;
        else if (advance)
            rcon <= xtime(rcon);
    end

    // key words
    always_ff @(posedge OK_addRK)
    begin
        if (load)
            round_key <= cipher_key;
        else if (advance)
            round_key <= next_key;
    end

endmodule

//--- rtl/aes_host_regs.sv
`timescale 1ns/1ns
/*
 * host write port, four-phase req/ack
 * decodes host words into key, plaintext and the start pulse
 */
module aes_host_regs
    import aes_pkg::*;
(
    input  logic           OK_addRK,
    input  logic           resetn,
    input  logic           host_req,
    input  aes_addr_e      host_addr,
    input  aes_host_word_u host_word,
    output logic           host_ack,
    input  logic           idle,
    output logic           go,
    output aes_state_t     cipher_key,
    output aes_state_t     plaintext
);

    logic is_start;
    logic accept;

    // control view of the word, only the start flag matters
    assign is_start = (host_addr == ADDR_CTRL) && host_word.ctrl.flags[flag_start];

    // new request; a start word waits for an idle engine
    assign accept = host_req && !host_ack && (!is_start || idle);

    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
        begin
            host_ack <= 1'b0;
            go       <= 1'b0;
        end
        else
        begin
            // one-cycle pulse alongside the ack edge
            go <= accept && is_start;
            if (accept)
                host_ack <= 1'b1;
            else if (!host_req)
                host_ack <= 1'b0;
        end
    end

    // state view of the word, captured on the ack edge
    always_ff @(posedge OK_addRK)
    begin
        if (accept)
        begin
            case (host_addr)
                ADDR_KEY:  cipher_key <= host_word.state;
                ADDR_DATA: plaintext  <= host_word.state;
                // control words and code 3 leave key and data alone
                default:   ;
            endcase
        end
    end

endmodule

//--- rtl/aes_round_ctrl.sv
`timescale 1ns/1ns
/*
 * round sequencer of the encryption engine
 * state register, round counter, key commands, result handshake
 */
module aes_round_ctrl
    import aes_pkg::*;
#(
    parameter int n_rounds = 10
)
(
    input  logic        OK_addRK,
    input  logic        resetn,
    input  logic        go,
    input  aes_state_t  plaintext,
    input  aes_state_t  round_key,
    input  aes_state_t  round_out,
    output aes_state_t  state,
    output logic        last_round,
    output logic        key_load,
    output logic        key_advance,
    output logic        idle,
    output aes_result_t result,
    output logic        result_req,
    input  logic        result_ack
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDKEY,
        S_ROUND,
        S_RESULT,
        S_RELEASE
    } fsm_e;

    fsm_e       fsm;
    logic [3:0] round_cnt;
    logic       final_round;

    assign final_round = (round_cnt == 4'(n_rounds));
    assign idle        = (fsm == S_IDLE);
    // key copied together with the plaintext
    assign key_load    = go && idle;
    // no key step after the final round
    assign key_advance = (fsm == S_ADDKEY) || ((fsm == S_ROUND) && !final_round);
    assign last_round  = (fsm == S_ROUND) && final_round;

    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
        begin
            fsm        <= S_IDLE;
            round_cnt  <= 4'd0;
            result_req <= 1'b0;
        end
        else
        begin
            case (fsm)
                S_IDLE:
                    if (go)
                        fsm <= S_ADDKEY;
                S_ADDKEY:
                begin
                    round_cnt <= 4'd1;
                    fsm       <= S_ROUND;
                end
                // last round goes straight into the result register
                S_ROUND:
                    if (final_round)
                    begin
                        result_req <= 1'b1;
                        fsm        <= S_RESULT;
                    end
                    else
                        round_cnt <= round_cnt + 4'd1;
                S_RESULT:
                    if (result_ack)
                    begin
                        result_req <= 1'b0;
                        fsm        <= S_RELEASE;
                    end
                // wait for ack low before taking a new start
                S_RELEASE:
                    if (!result_ack)
                        fsm <= S_IDLE;
                default:
                    fsm <= S_IDLE;
            endcase
        end
    end

    // plaintext copy, initial key addition, then one round per clock
    always_ff @(posedge OK_addRK)
    begin
        if (key_load)
            state <= plaintext;
        else if (fsm == S_ADDKEY)
            state <= state ^ round_key;
        else if ((fsm == S_ROUND) && !final_round)
            state <= round_out;
        // result stays put while result_req is high
        if (last_round)
        begin
            result.data   <= round_out;
            result.rounds <= round_cnt;
        end
    end

endmodule

//--- rtl/aes_enc_top.sv
`timescale 1ns/1ns
/*
 * AES-128 encryption engine, top level
 * host registers, round sequencer, round datapath, key expansion
 */
module aes_enc_top
    import aes_pkg::*;
#(
    parameter int n_rounds = 10
)
(
    input  logic           OK_addRK,
    input  logic           resetn,
    input  logic           host_req,
    input  aes_addr_e      host_addr,
    input  aes_host_word_u host_word,
    output logic           host_ack,
    output aes_result_t    result,
    output logic           result_req,
    input  logic           result_ack
);

    logic       go;
    logic       idle;
    logic       last_round;
    logic       key_load;
    logic       key_advance;
    aes_state_t cipher_key;
    aes_state_t plaintext;
    aes_state_t round_key;
    aes_state_t round_out;
    aes_state_t state;

    aes_host_regs u_host_regs (
        .OK_addRK   (OK_addRK),
        .resetn     (resetn),
        .host_req   (host_req),
        .host_addr  (host_addr),
        .host_word  (host_word),
        .host_ack   (host_ack),
        .idle       (idle),
        .go         (go),
        .cipher_key (cipher_key),
        .plaintext  (plaintext)
    );

    aes_round_ctrl #(
        .n_rounds (n_rounds)
    ) u_round_ctrl (
        .OK_addRK    (OK_addRK),
        .resetn      (resetn),
        .go          (go),
        .plaintext   (plaintext),
        .round_key   (round_key),
        .round_out   (round_out),
        .state       (state),
        .last_round  (last_round),
        .key_load    (key_load),
        .key_advance (key_advance),
        .idle        (idle),
        .result      (result),
        .result_req  (result_req),
        .result_ack  (result_ack)
    );

    aes_round_datapath u_datapath (
        .state_in   (state),
        .round_key  (round_key),
        .last_round (last_round),
        .state_out  (round_out)
    );

    aes_round_key u_round_key (
        .OK_addRK   (OK_addRK),
        .resetn     (resetn),
        .load       (key_load),
        .advance    (key_advance),
        .cipher_key (cipher_key),
        .round_key  (round_key)
    );

endmodule

//--- include/aes_ref_model.svh
/*
 * reference model for the testbench
 * byte multiply, S-box by inverse search, key schedule step,
 * AES-128 encryption with a selectable round count
 */
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// GF(2^8) product, poly 0x11b
function automatic logic [7:0] ref_gmul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++)
    begin
        if (b[i])
            p ^= x;
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
endfunction

// inverse found by trying every byte, then affine step
function automatic logic [7:0] ref_sbox(input logic [7:0] a);
    logic [7:0] inv;
    logic [7:0] s;
    inv = 8'h00;
    for (int i = 1; i < 256; i++)
    begin
        if (ref_gmul(a, 8'(i)) == 8'h01)
            inv = 8'(i);
    end
    s = 8'h63;
    for (int k = 0; k < 5; k++)
        s ^= (inv << k) | (inv >> (8 - k));
    return s;
endfunction

// one key schedule step
function automatic logic [0:15][7:0] ref_next_key(input logic [0:15][7:0] k,
                                                  input logic [7:0] rcon);
    logic [0:15][7:0] n;
    for (int j = 0; j < 4; j++)
        n[j] = k[j] ^ ref_sbox(k[12 + (j + 1) % 4]) ^ ((j == 0) ? rcon : 8'h00);
    for (int i = 4; i < 16; i++)
        n[i] = k[i] ^ n[i - 4];
    return n;
endfunction

// full encryption, MixColumns skipped in the last round
function automatic logic [0:15][7:0] ref_encrypt(input logic [0:15][7:0] key,
                                                 input logic [0:15][7:0] pt,
                                                 input int rounds);
    logic [0:15][7:0] s;
    logic [0:15][7:0] t;
    logic [0:15][7:0] k;
    logic [7:0]       rcon;
    k    = key;
    s    = pt ^ key;
    rcon = 8'h01;
    for (int r = 1; r <= rounds; r++)
    begin
        k    = ref_next_key(k, rcon);
        rcon = ref_gmul(rcon, 8'h02);
        for (int i = 0; i < 16; i++)
            t[i] = ref_sbox(s[4*((i/4 + i%4) % 4) + i%4]);
        s = t;
        if (r != rounds)
        begin
            for (int i = 0; i < 16; i++)
                s[i] = ref_gmul(t[i], 8'h02) ^ ref_gmul(t[4*(i/4) + (i%4 + 1) % 4], 8'h03)
                     ^ t[4*(i/4) + (i%4 + 2) % 4] ^ t[4*(i/4) + (i%4 + 3) % 4];
        end
        s ^= k;
    end
    return s;
endfunction

`endif

//--- tb/tb_aes_enc.sv
`timescale 1ns/1ns
/*
 * testbench of the AES-128 encryption engine
 * host and result handshakes, known answer, random runs,
 * start back-pressure, writes during a run, ignored words
 */
module tb_aes_enc
    import aes_pkg::*;
();

    `include "aes_ref_model.svh"

    localparam int n_rounds  = 10;
    // ack of the start word to result_req
    localparam int latency   = n_rounds + 2;
    localparam int ack_limit = 64;
    localparam int req_limit = 64;
    localparam int n_random  = 200;
    // FIPS-197 appendix C.1
    localparam logic [127:0] kat_key = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] kat_pt  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] kat_ct  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic           OK_addRK;
    logic           resetn;
    logic           host_req;
    aes_addr_e      host_addr;
    aes_host_word_u host_word;
    logic           host_ack;
    aes_result_t    result;
    logic           result_req;
    logic           result_ack;

    // what the DUT should hold after the acked writes
    aes_state_t cur_key;
    aes_state_t cur_pt;
    // one entry per accepted start word
    aes_state_t exp_key_q[$];
    aes_state_t exp_pt_q[$];
    int         ack_cyc_q[$];
    int         cycle;
    int         checked;
    logic       req_seen;
    aes_state_t last_ct;

    aes_enc_top #(
        .n_rounds (n_rounds)
    ) uut (
        .OK_addRK   (OK_addRK),
        .resetn     (resetn),
        .host_req   (host_req),
        .host_addr  (host_addr),
        .host_word  (host_word),
        .host_ack   (host_ack),
        .result     (result),
        .result_req (result_req),
        .result_ack (result_ack)
    );

    // 8 ns period
    always #4 OK_addRK = ~OK_addRK;

    // rising edges since time 0
    always @(posedge OK_addRK)
        cycle <= cycle + 1;

    task automatic report_error(input string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    function automatic aes_state_t rand_state();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    task automatic wait_host_ack(input logic level);
        int n;
        n = 0;
        while (host_ack !== level)
        begin
            @(negedge OK_addRK);
            n++;
            if (n > ack_limit)
                report_error($sformatf("timeout waiting for host_ack to go %0d", level));
        end
    endtask

    task automatic wait_result_req(input logic level);
        int n;
        n = 0;
        while (result_req !== level)
        begin
            @(negedge OK_addRK);
            n++;
            if (n > req_limit)
                report_error($sformatf("timeout waiting for result_req to go %0d", level));
        end
    endtask

    // track what an acked word did and queue an expectation per start word
    task automatic note_accept(input aes_addr_e addr, input aes_host_word_u word);
        case (addr)
            ADDR_KEY:  cur_key = word.state;
            ADDR_DATA: cur_pt  = word.state;
            ADDR_CTRL:
                if (word.ctrl.flags[0])
                begin
                    exp_key_q.push_back(cur_key);
                    exp_pt_q.push_back(cur_pt);
                    ack_cyc_q.push_back(cycle);
                end
            default: ;
        endcase
    endtask

    // full four-phase write starting on a falling edge
    task automatic host_write(input aes_addr_e addr, input aes_host_word_u word);
        host_addr = addr;
        host_word = word;
        host_req  = 1'b1;
        @(negedge OK_addRK);
        wait_host_ack(1'b1);
        note_accept(addr, word);
        host_req = 1'b0;
        @(negedge OK_addRK);
        wait_host_ack(1'b0);
    endtask

    task automatic write_state(input aes_addr_e addr, input aes_state_t s);
        aes_host_word_u w;
        w.state = s;
        host_write(addr, w);
    endtask

    // random reserved bits for the DUT to ignore
    task automatic send_ctrl(input logic [7:0] flags);
        aes_host_word_u w;
        w.state      = rand_state();
        w.ctrl.flags = flags;
        host_write(ADDR_CTRL, w);
    endtask

    // four-phase result read that keeps the ciphertext
    task automatic take_result();
        wait_result_req(1'b1);
        last_ct    = result.data;
        result_ack = 1'b1;
        @(negedge OK_addRK);
        wait_result_req(1'b0);
        result_ack = 1'b0;
        @(negedge OK_addRK);
    endtask

    task automatic check_result();
        aes_state_t exp_ct;
        int         lat;
        assert (exp_key_q.size() > 0)
        else
            report_error("result_req rose although no start word was accepted");
        exp_ct = ref_encrypt(exp_key_q.pop_front(), exp_pt_q.pop_front(), n_rounds);
        lat    = cycle - ack_cyc_q.pop_front();
        assert (result.data == exp_ct)
        else
            report_error($sformatf("ERR result.data got %h expected %h", result.data, exp_ct));
        assert (result.rounds == 4'(n_rounds))
        else
            report_error($sformatf("ERR result.rounds got %h expected %h",
                                   result.rounds, 4'(n_rounds)));
        assert (lat == latency)
        else
            report_error($sformatf("ERR result_req latency got %h expected %h", lat, latency));
        checked++;
    endtask

    // compare on each rising result_req
    always @(negedge OK_addRK)
    begin
        if (resetn && result_req && !req_seen)
            check_result();
        req_seen = result_req;
    end

    initial
    begin
        aes_host_word_u w;
        void'($urandom(32'hb0d1));
        OK_addRK   = 1'b0;
        resetn     = 1'b0;
        host_req   = 1'b0;
        host_addr  = ADDR_CTRL;
        host_word  = '0;
        result_ack = 1'b0;
        cur_key    = '0;
        cur_pt     = '0;
        cycle      = 0;
        checked    = 0;
        req_seen   = 1'b0;
        repeat (5) @(negedge OK_addRK);
        resetn = 1'b1;
        assert (!host_ack && !result_req)
        else
            report_error("host_ack or result_req high after reset");

        // known answer
        write_state(ADDR_KEY, kat_key);
        write_state(ADDR_DATA, kat_pt);
        send_ctrl(8'h01);
        take_result();
        assert (last_ct == kat_ct)
        else
            report_error($sformatf("ERR result.data got %h expected %h", last_ct, kat_ct));

        // random keys, plaintexts and other flag bits
        for (int i = 0; i < n_random; i++)
        begin
            write_state(ADDR_KEY, rand_state());
            write_state(ADDR_DATA, rand_state());
            send_ctrl(8'($urandom()) | 8'h01);
            take_result();
        end

        // start word while a result is pending
        write_state(ADDR_KEY, rand_state());
        write_state(ADDR_DATA, rand_state());
        send_ctrl(8'h01);
        wait_result_req(1'b1);
        write_state(ADDR_KEY, rand_state());
        write_state(ADDR_DATA, rand_state());
        w.state      = rand_state();
        w.ctrl.flags = 8'h01;
        host_addr    = ADDR_CTRL;
        host_word    = w;
        host_req     = 1'b1;
        repeat (10)
        begin
            @(negedge OK_addRK);
            assert (!host_ack)
            else
                report_error("start word acknowledged while a result was pending");
        end
        take_result();
        wait_host_ack(1'b1);
        note_accept(ADDR_CTRL, w);
        host_req = 1'b0;
        @(negedge OK_addRK);
        wait_host_ack(1'b0);
        take_result();

        // key and data writes inside a running encryption
        write_state(ADDR_KEY, rand_state());
        write_state(ADDR_DATA, rand_state());
        send_ctrl(8'h01);
        write_state(ADDR_KEY, rand_state());
        write_state(ADDR_DATA, rand_state());
        assert (!result_req)
        else
            report_error("encryption finished before the key and data writes were done");
        take_result();
        send_ctrl(8'h01);
        take_result();

        // no start flag and then address 3 with bit 0 set
        send_ctrl(8'hfe);
        w.state = rand_state() | 128'h1;
        host_write(aes_addr_e'(2'd3), w);
        repeat (20)
        begin
            @(negedge OK_addRK);
            assert (!result_req)
            else
                report_error("result_req rose after a word that carries no start");
        end
        // key and data untouched by the ignored words
        send_ctrl(8'h01);
        take_result();

        $display("checked %0d results", checked);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- build.f
+incdir+include
rtl/aes_pkg.sv
rtl/aes_sbox.sv
rtl/aes_mix_columns.sv
rtl/aes_round_datapath.sv
rtl/aes_round_key.sv
rtl/aes_host_regs.sv
rtl/aes_round_ctrl.sv
rtl/aes_enc_top.sv
tb/tb_aes_enc.sv
